// File: hw/mips_pkg.sv
// integer subset only (add sub and or slt addi lw sw beq); anything else decodes as a bubble
package mips_pkg;

   localparam int XLEN   = 32;
   localparam int REG_AW = 5;

   typedef logic [XLEN-1:0]   word_t;
   typedef logic [REG_AW-1:0] reg_idx_t;

   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_BEQ   = 6'h04,
      OP_ADDI  = 6'h08,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2b
   } opcode_t;

   typedef enum logic [5:0] {
      F_ADD = 6'h20,
      F_SUB = 6'h22,
      F_AND = 6'h24,
      F_OR  = 6'h25,
      F_SLT = 6'h2a
   } funct_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } alu_op_t;

   typedef struct packed {
      opcode_t    opcode;
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [4:0] shamt;
      funct_t     funct;
   } r_fmt_t;

   typedef struct packed {
      opcode_t     opcode;
      reg_idx_t    rs;
      reg_idx_t    rt;
      logic [15:0] imm;
   } i_fmt_t;

   // same word seen as register form or immediate form
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

   typedef struct packed {
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    mem_to_reg;
      logic    alu_src;
      logic    reg_dst;
      logic    branch;
      alu_op_t alu_op;
   } ctrl_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    rs_data;
      word_t    rt_data;
      word_t    imm_ext;
      word_t    pc_plus4;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
   } id_ex_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    alu_result;
      word_t    store_data;
      reg_idx_t dest;
   } ex_mem_t;

   typedef struct packed {
      logic     reg_write;
      logic     mem_to_reg;
      word_t    alu_result;
      word_t    load_data;
      reg_idx_t dest;
   } mem_wb_t;

   typedef enum logic [1:0] {
      FWD_RF,
      FWD_EXMEM,
      FWD_MEMWB
   } fwd_sel_t;

   typedef struct packed {
      logic  re;
      logic  we;
      word_t addr;
      word_t wdata;
   } dmem_req_t;

   typedef struct packed {
      logic  taken;
      word_t target;
   } redirect_t;

endpackage

// File: hw/fetch_stage.sv
// instruction memory read is combinational; redirect has priority over stall
`timescale 1ns/1ps

module fetch_stage #(
   parameter mips_pkg::word_t RESET_PC = '0
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                stall_i,
   input  mips_pkg::redirect_t redirect_i,
   output mips_pkg::word_t     imem_addr_o,
   input  mips_pkg::instr_u    imem_data_i,
   output mips_pkg::instr_u    if_instr_o,
   output mips_pkg::word_t     if_pc_plus4_o
);

   import mips_pkg::*;

   word_t pc_q;
   word_t pc_plus4;

   assign pc_plus4    = pc_q + XLEN'(4);
   assign imem_addr_o = pc_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc_q <= RESET_PC;
      end else if (redirect_i.taken) begin
         pc_q <= redirect_i.target;
      end else if (!stall_i) begin
         pc_q <= pc_plus4;
      end
   end

   // zero word decodes as a bubble
   always_ff @(posedge clk) begin
      if (!rst_n || redirect_i.taken) begin
         if_instr_o <= '0;
      end else if (!stall_i) begin
         if_instr_o <= imem_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall_i) begin
         if_pc_plus4_o <= pc_plus4;
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n) pc_q[1:0] == 2'b00);

endmodule

// File: hw/pipe_ctrl.sv
// purely combinational; stall is conservative on rs and only checks rt where it is a source
`timescale 1ns/1ps

module pipe_ctrl (
   input  mips_pkg::instr_u   if_instr_i,
   input  mips_pkg::reg_idx_t idex_rs_i,
   input  mips_pkg::reg_idx_t idex_rt_i,
   input  logic               idex_mem_read_i,
   input  mips_pkg::ex_mem_t  exmem_i,
   input  mips_pkg::mem_wb_t  memwb_i,
   output mips_pkg::ctrl_t    id_ctrl_o,
   output logic               stall_o,
   output mips_pkg::fwd_sel_t fwd_a_o,
   output mips_pkg::fwd_sel_t fwd_b_o
);

   import mips_pkg::*;

   ctrl_t dec;
   logic  uses_rt;

   // EX/MEM wins over MEM/WB, it holds the younger result
   function automatic fwd_sel_t fwd_pick(reg_idx_t src, ex_mem_t exm, mem_wb_t mwb);
      if (exm.ctrl.reg_write && exm.dest != '0 && exm.dest == src) begin
         return FWD_EXMEM;
      end else if (mwb.reg_write && mwb.dest != '0 && mwb.dest == src) begin
         return FWD_MEMWB;
      end
      return FWD_RF;
   endfunction

   always_comb begin
      dec = '0;
      case (if_instr_i.r.opcode)
         OP_RTYPE: begin
            dec.reg_write = 1'b1;
            dec.reg_dst   = 1'b1;
            case (if_instr_i.r.funct)
               F_ADD:   dec.alu_op = ALU_ADD;
               F_SUB:   dec.alu_op = ALU_SUB;
               F_AND:   dec.alu_op = ALU_AND;
               F_OR:    dec.alu_op = ALU_OR;
               F_SLT:   dec.alu_op = ALU_SLT;
               default: dec = '0;
            endcase
         end
         OP_ADDI: begin
            dec.reg_write = 1'b1;
            dec.alu_src   = 1'b1;
         end
         OP_LW: begin
            dec.reg_write  = 1'b1;
            dec.mem_read   = 1'b1;
            dec.mem_to_reg = 1'b1;
            dec.alu_src    = 1'b1;
         end
         OP_SW: begin
            dec.mem_write = 1'b1;
            dec.alu_src   = 1'b1;
         end
         OP_BEQ: begin
            dec.branch = 1'b1;
            dec.alu_op = ALU_SUB;
         end
         default: dec = '0;
      endcase
   end

   // rt is a destination for addi and lw
   assign uses_rt = (if_instr_i.r.opcode == OP_RTYPE) || (if_instr_i.r.opcode == OP_SW) ||
                    (if_instr_i.r.opcode == OP_BEQ);

   // load-use: hold IF and ID one cycle
   assign stall_o = idex_mem_read_i && idex_rt_i != '0 &&
                    (idex_rt_i == if_instr_i.r.rs || (uses_rt && idex_rt_i == if_instr_i.r.rt));

   assign id_ctrl_o = stall_o ? '0 : dec;

   assign fwd_a_o = fwd_pick(idex_rs_i, exmem_i, memwb_i);
   assign fwd_b_o = fwd_pick(idex_rt_i, exmem_i, memwb_i);

   // r0 must never hold up the pipe or be bypassed from EX/MEM
   always_comb begin
      if (stall_o) begin
         assert final (idex_rt_i != '0);
      end
      if (fwd_a_o == FWD_EXMEM) begin
         assert final (exmem_i.dest != '0 && idex_rs_i != '0);
      end
      if (fwd_b_o == FWD_EXMEM) begin
         assert final (exmem_i.dest != '0 && idex_rt_i != '0);
      end
   end

endmodule

// File: hw/reg_file.sv
// r0 reads as zero; a read of the register under writeback returns the new value
`timescale 1ns/1ps

module reg_file (
   input  logic               clk,
   input  logic               rst_n,
   input  mips_pkg::reg_idx_t rs_i,
   input  mips_pkg::reg_idx_t rt_i,
   input  mips_pkg::mem_wb_t  wb_i,
   input  mips_pkg::word_t    wb_data_i,
   output mips_pkg::word_t    rs_data_o,
   output mips_pkg::word_t    rt_data_o
);

   import mips_pkg::*;

   word_t regs [2**REG_AW];

   function automatic word_t read_port(reg_idx_t idx, mem_wb_t wb, word_t wb_data,
                                       word_t cur);
      if (idx == '0) begin
         return '0;
      end else if (wb.reg_write && wb.dest == idx) begin
         return wb_data;
      end
      return cur;
   endfunction

   always_ff @(posedge clk) begin
      if (rst_n && wb_i.reg_write && wb_i.dest != '0) begin
         regs[wb_i.dest] <= wb_data_i;
      end
   end

   // write-through stands in for the first-half-cycle write
   assign rs_data_o = read_port(rs_i, wb_i, wb_data_i, regs[rs_i]);
   assign rt_data_o = read_port(rt_i, wb_i, wb_data_i, regs[rt_i]);

endmodule

// File: hw/exec_stage.sv
// beq resolves here with forwarded operands; a taken branch bubbles the decode slot
`timescale 1ns/1ps

module exec_stage (
   input  logic                clk,
   input  logic                rst_n,
   input  mips_pkg::ctrl_t     id_ctrl_i,
   input  mips_pkg::instr_u    if_instr_i,
   input  mips_pkg::word_t     if_pc_plus4_i,
   input  mips_pkg::word_t     rs_data_i,
   input  mips_pkg::word_t     rt_data_i,
   input  mips_pkg::fwd_sel_t  fwd_a_i,
   input  mips_pkg::fwd_sel_t  fwd_b_i,
   input  mips_pkg::word_t     wb_data_i,
   output mips_pkg::reg_idx_t  idex_rs_o,
   output mips_pkg::reg_idx_t  idex_rt_o,
   output logic                idex_mem_read_o,
   output mips_pkg::redirect_t redirect_o,
   output mips_pkg::ex_mem_t   ex_mem_o
);

   import mips_pkg::*;

   id_ex_t  idex_d;
   id_ex_t  idex_q;
   ex_mem_t exmem_d;
   ex_mem_t exmem_q;
   word_t   op_a;
   word_t   op_b_reg;
   word_t   op_b;
   word_t   alu_y;

   function automatic word_t fwd_mux(fwd_sel_t sel, word_t rf, word_t exm, word_t wb);
      case (sel)
         FWD_EXMEM: return exm;
         FWD_MEMWB: return wb;
         default:   return rf;
      endcase
   endfunction

   always_comb begin
      idex_d.ctrl     = redirect_o.taken ? '0 : id_ctrl_i;
      idex_d.rs_data  = rs_data_i;
      idex_d.rt_data  = rt_data_i;
      idex_d.imm_ext  = {{(XLEN-16){if_instr_i.i.imm[15]}}, if_instr_i.i.imm};
      idex_d.pc_plus4 = if_pc_plus4_i;
      idex_d.rs       = if_instr_i.r.rs;
      idex_d.rt       = if_instr_i.r.rt;
      idex_d.rd       = if_instr_i.r.rd;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         idex_q.ctrl <= '0;
      end else begin
         idex_q <= idex_d;
      end
   end

   assign op_a     = fwd_mux(fwd_a_i, idex_q.rs_data, exmem_q.alu_result, wb_data_i);
   assign op_b_reg = fwd_mux(fwd_b_i, idex_q.rt_data, exmem_q.alu_result, wb_data_i);
   assign op_b     = idex_q.ctrl.alu_src ? idex_q.imm_ext : op_b_reg;

   always_comb begin
      case (idex_q.ctrl.alu_op)
         ALU_ADD: alu_y = op_a + op_b;
         ALU_SUB: alu_y = op_a - op_b;
         ALU_AND: alu_y = op_a & op_b;
         ALU_OR:  alu_y = op_a | op_b;
         ALU_SLT: alu_y = word_t'($signed(op_a) < $signed(op_b));
         default: alu_y = '0;
      endcase
   end

   // not-taken prediction, so only a taken beq redirects
   assign redirect_o.taken  = idex_q.ctrl.branch && (op_a == op_b_reg);
   assign redirect_o.target = idex_q.pc_plus4 + {idex_q.imm_ext[XLEN-3:0], 2'b00};

   always_comb begin
      exmem_d.ctrl       = idex_q.ctrl;
      exmem_d.alu_result = alu_y;
      exmem_d.store_data = op_b_reg;
      exmem_d.dest       = idex_q.ctrl.reg_dst ? idex_q.rd : idex_q.rt;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         exmem_q.ctrl <= '0;
      end else begin
         exmem_q <= exmem_d;
      end
   end

   assign idex_rs_o       = idex_q.rs;
   assign idex_rt_o       = idex_q.rt;
   assign idex_mem_read_o = idex_q.ctrl.mem_read;
   assign ex_mem_o        = exmem_q;

   // the bubble it inserts cannot branch again
   assert property (@(posedge clk) disable iff (!rst_n) redirect_o.taken |=> !redirect_o.taken);

endmodule

// File: hw/mem_wb_stage.sv
// data memory answers reads combinationally and writes on the rising edge while we is high
`timescale 1ns/1ps

module mem_wb_stage (
   input  logic                clk,
   input  logic                rst_n,
   input  mips_pkg::ex_mem_t   ex_mem_i,
   output mips_pkg::dmem_req_t dmem_req_o,
   input  mips_pkg::word_t     dmem_rdata_i,
   output mips_pkg::mem_wb_t   memwb_o,
   output mips_pkg::word_t     wb_data_o
);

   import mips_pkg::*;

   mem_wb_t memwb_d;
   mem_wb_t memwb_q;

   assign dmem_req_o.re    = ex_mem_i.ctrl.mem_read;
   assign dmem_req_o.we    = ex_mem_i.ctrl.mem_write;
   assign dmem_req_o.addr  = ex_mem_i.alu_result;
   assign dmem_req_o.wdata = ex_mem_i.store_data;

   always_comb begin
      memwb_d.reg_write  = ex_mem_i.ctrl.reg_write;
      memwb_d.mem_to_reg = ex_mem_i.ctrl.mem_to_reg;
      memwb_d.alu_result = ex_mem_i.alu_result;
      memwb_d.load_data  = dmem_rdata_i;
      memwb_d.dest       = ex_mem_i.dest;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         memwb_q.reg_write  <= 1'b0;
         memwb_q.mem_to_reg <= 1'b0;
      end else begin
         memwb_q <= memwb_d;
      end
   end

   assign memwb_o   = memwb_q;
   assign wb_data_o = memwb_q.mem_to_reg ? memwb_q.load_data : memwb_q.alu_result;

   // decoder never marks one instruction as both load and store
   assert property (@(posedge clk) disable iff (!rst_n) !(dmem_req_o.re && dmem_req_o.we));

endmodule

// File: hw/mips_pipe.sv
// memories must answer in the same cycle; no exceptions, no jumps, branches predicted not taken
`timescale 1ns/1ps

module mips_pipe #(
   parameter mips_pkg::word_t RESET_PC = '0
) (
   input  logic                clk,
   input  logic                rst_n,
   output mips_pkg::word_t     imem_addr_o,
   input  mips_pkg::instr_u    imem_data_i,
   output mips_pkg::dmem_req_t dmem_req_o,
   input  mips_pkg::word_t     dmem_rdata_i
);

   import mips_pkg::*;

   instr_u    if_instr;
   word_t     if_pc_plus4;
   ctrl_t     id_ctrl;
   logic      stall;
   fwd_sel_t  fwd_a;
   fwd_sel_t  fwd_b;
   redirect_t redirect;
   ex_mem_t   ex_mem;
   reg_idx_t  idex_rs;
   reg_idx_t  idex_rt;
   logic      idex_mem_read;
   mem_wb_t   wb;
   word_t     wb_data;
   word_t     rs_data;
   word_t     rt_data;

   fetch_stage #(.RESET_PC(RESET_PC)) fetch_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .stall_i       (stall),
      .redirect_i    (redirect),
      .imem_addr_o   (imem_addr_o),
      .imem_data_i   (imem_data_i),
      .if_instr_o    (if_instr),
      .if_pc_plus4_o (if_pc_plus4)
   );

   pipe_ctrl ctrl_i (
      .if_instr_i      (if_instr),
      .idex_rs_i       (idex_rs),
      .idex_rt_i       (idex_rt),
      .idex_mem_read_i (idex_mem_read),
      .exmem_i         (ex_mem),
      .memwb_i         (wb),
      .id_ctrl_o       (id_ctrl),
      .stall_o         (stall),
      .fwd_a_o         (fwd_a),
      .fwd_b_o         (fwd_b)
   );

   reg_file regs_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .rs_i      (if_instr.r.rs),
      .rt_i      (if_instr.r.rt),
      .wb_i      (wb),
      .wb_data_i (wb_data),
      .rs_data_o (rs_data),
      .rt_data_o (rt_data)
   );

   exec_stage exec_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .id_ctrl_i       (id_ctrl),
      .if_instr_i      (if_instr),
      .if_pc_plus4_i   (if_pc_plus4),
      .rs_data_i       (rs_data),
      .rt_data_i       (rt_data),
      .fwd_a_i         (fwd_a),
      .fwd_b_i         (fwd_b),
      .wb_data_i       (wb_data),
      .idex_rs_o       (idex_rs),
      .idex_rt_o       (idex_rt),
      .idex_mem_read_o (idex_mem_read),
      .redirect_o      (redirect),
      .ex_mem_o        (ex_mem)
   );

   mem_wb_stage mem_wb_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .ex_mem_i     (ex_mem),
      .dmem_req_o   (dmem_req_o),
      .dmem_rdata_i (dmem_rdata_i),
      .memwb_o      (wb),
      .wb_data_o    (wb_data)
   );

endmodule

// File: tests/mips_pipe_tests.svh
// test tasks and the program builder; every program starts at RESET_PC and stays below 0x400
`ifndef MIPS_PIPE_TESTS_SVH
`define MIPS_PIPE_TESTS_SVH

   function automatic instr_u rtype_word(funct_t f, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
      instr_u w;
      w.r.opcode = OP_RTYPE;
      w.r.rs     = rs;
      w.r.rt     = rt;
      w.r.rd     = rd;
      w.r.shamt  = 5'd0;
      w.r.funct  = f;
      return w;
   endfunction

   function automatic instr_u itype_word(opcode_t op, reg_idx_t rt, reg_idx_t rs,
                                         logic [15:0] imm);
      instr_u w;
      w.i.opcode = op;
      w.i.rs     = rs;
      w.i.rt     = rt;
      w.i.imm    = imm;
      return w;
   endfunction

   function automatic word_t sext16(logic [15:0] imm);
      return {{16{imm[15]}}, imm};
   endfunction

   task automatic place_word(input instr_u w);
      imem[pc_slot] = w;
      pc_slot++;
   endtask

   // false while the model walks the shadow of a taken branch
   function automatic bit on_path();
      if (skip_n > 0) begin
         skip_n--;
         return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic write_model(input reg_idx_t r, input word_t v);
      if (r != 5'd0) begin
         model_regs[r] = v;
      end
   endtask

   task automatic immediate_add(input reg_idx_t rt, input reg_idx_t rs, input logic [15:0] imm);
      place_word(itype_word(OP_ADDI, rt, rs, imm));
      if (on_path()) begin
         write_model(rt, model_regs[rs] + sext16(imm));
      end
   endtask

   task automatic register_op(input funct_t f, input reg_idx_t rd, input reg_idx_t rs,
                              input reg_idx_t rt);
      word_t a;
      word_t b;
      word_t y;
      a = model_regs[rs];
      b = model_regs[rt];
      case (f)
         F_ADD:   y = a + b;
         F_SUB:   y = a - b;
         F_AND:   y = a & b;
         F_OR:    y = a | b;
         default: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      endcase
      place_word(rtype_word(f, rd, rs, rt));
      if (on_path()) begin
         write_model(rd, y);
      end
   endtask

   task automatic load_word(input reg_idx_t rt, input reg_idx_t rs, input logic [15:0] off);
      word_t addr;
      place_word(itype_word(OP_LW, rt, rs, off));
      if (on_path()) begin
         addr = model_regs[rs] + sext16(off);
         write_model(rt, model_mem[addr[9:2]]);
      end
   endtask

   task automatic store_word(input reg_idx_t rt, input reg_idx_t rs, input logic [15:0] off);
      dmem_req_t req;
      place_word(itype_word(OP_SW, rt, rs, off));
      if (on_path()) begin
         req.re    = 1'b0;
         req.we    = 1'b1;
         req.addr  = model_regs[rs] + sext16(off);
         req.wdata = model_regs[rt];
         model_mem[req.addr[9:2]] = req.wdata;
         expect_log.push_back(req);
      end
   endtask

   // forward branches only; off counts the skipped instructions
   task automatic branch_equal(input reg_idx_t rs, input reg_idx_t rt, input logic [15:0] off);
      place_word(itype_word(OP_BEQ, rt, rs, off));
      if (on_path() && model_regs[rs] == model_regs[rt]) begin
         skip_n = int'(off);
      end
   endtask

   task automatic reset_values;
      restart();
      check_word("reset", RESET_PC, imem_addr);
      check_word("reset", '0, word_t'({dmem_req.re, dmem_req.we}));
      rst_n = 1'b1;
      @(negedge clk);
      check_word("reset", RESET_PC + 32'd4, imem_addr);
   endtask

   // each result feeds the next, so operands come from EX/MEM and MEM/WB
   task automatic forwarding_chain;
      restart();
      immediate_add(5'd1, 5'd0, 16'hfff9);
      immediate_add(5'd2, 5'd1, 16'h0003);
      register_op(F_ADD, 5'd3, 5'd2, 5'd1);
      register_op(F_SUB, 5'd4, 5'd3, 5'd2);
      register_op(F_AND, 5'd5, 5'd4, 5'd3);
      register_op(F_OR, 5'd6, 5'd5, 5'd4);
      register_op(F_SLT, 5'd7, 5'd5, 5'd6);
      store_word(5'd7, 5'd0, 16'h0080);
      store_word(5'd6, 5'd0, 16'h0084);
      store_word(5'd5, 5'd0, 16'h0088);
      store_word(5'd4, 5'd0, 16'h008c);
      store_word(5'd3, 5'd0, 16'h0090);
      run_and_compare("forwarding_chain");
   endtask

   task automatic load_use_stall;
      restart();
      immediate_add(5'd1, 5'd0, 16'h0020);
      load_word(5'd2, 5'd1, 16'h0008);
      register_op(F_ADD, 5'd3, 5'd2, 5'd1);
      store_word(5'd3, 5'd1, 16'h0000);
      // reload feeds the store data directly
      load_word(5'd4, 5'd1, 16'h0000);
      store_word(5'd4, 5'd1, 16'h0004);
      run_and_compare("load_use_stall");
   endtask

   task automatic branch_shadow;
      restart();
      immediate_add(5'd1, 5'd0, 16'h0005);
      immediate_add(5'd3, 5'd0, 16'h0009);
      immediate_add(5'd2, 5'd0, 16'h0005);
      branch_equal(5'd1, 5'd2, 16'd2);
      store_word(5'd1, 5'd0, 16'h0104);
      store_word(5'd2, 5'd0, 16'h0108);
      store_word(5'd3, 5'd0, 16'h010c);
      branch_equal(5'd1, 5'd3, 16'd1);
      store_word(5'd1, 5'd0, 16'h0110);
      store_word(5'd2, 5'd0, 16'h0114);
      run_and_compare("branch_shadow");
   endtask

   task automatic zero_register;
      logic [15:0] imm;
      restart();
      draw_bits(16, imm);
      immediate_add(5'd0, 5'd0, imm);
      draw_bits(16, imm);
      immediate_add(5'd1, 5'd0, imm);
      register_op(F_OR, 5'd0, 5'd1, 5'd1);
      store_word(5'd0, 5'd0, 16'h0100);
      load_word(5'd0, 5'd0, 16'h0104);
      store_word(5'd0, 5'd0, 16'h0108);
      draw_bits(16, imm);
      immediate_add(5'd0, 5'd1, imm);
      store_word(5'd0, 5'd0, 16'h010c);
      run_and_compare("zero_register");
   endtask

   task automatic mixed_alu;
      funct_t      ops [5] = '{F_ADD, F_SUB, F_AND, F_OR, F_SLT};
      logic [15:0] imm;
      reg_idx_t    cur;
      reg_idx_t    prev;
      reg_idx_t    rd;
      restart();
      for (int k = 0; k < 12; k++) begin
         draw_bits(16, imm);
         cur  = reg_idx_t'(1 + k % 6);
         prev = (k == 0) ? 5'd0 : reg_idx_t'(1 + (k - 1) % 6);
         rd   = reg_idx_t'(10 + k % 3);
         immediate_add(cur, prev, imm);
         store_word(cur, 5'd0, 16'(32'h200 + 8 * k));
         register_op(ops[k % 5], rd, cur, prev);
         store_word(rd, 5'd0, 16'(32'h204 + 8 * k));
      end
      run_and_compare("mixed_alu");
   endtask

`endif

// File: tests/mips_pipe_tb.sv
// RESET_PC is 0x40; both memory models hold 256 words, so byte addresses wrap above 0x3ff
`timescale 1ns/1ps

module mips_pipe_tb;

   import mips_pkg::*;

   localparam word_t RESET_PC = 32'h0000_0040;
   // far above the summed program lengths, resets and drain included
   localparam int CYCLE_LIMIT = 2000;

   logic        clk;
   logic        rst_n;
   word_t       imem_addr;
   instr_u      imem_data;
   dmem_req_t   dmem_req;
   word_t       dmem_rdata;

   instr_u      imem [256];
   word_t       dmem [256];
   word_t       model_mem [256];
   word_t       model_regs [32];
   dmem_req_t   store_log [$];
   dmem_req_t   expect_log [$];
   int          pc_slot;
   int          skip_n;
   int          cycles;
   logic [15:0] lfsr_state;

   mips_pipe #(.RESET_PC(RESET_PC)) mips_pipe_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .imem_addr_o  (imem_addr),
      .imem_data_i  (imem_data),
      .dmem_req_o   (dmem_req),
      .dmem_rdata_i (dmem_rdata)
   );

   // both memories answer in the same cycle
   assign imem_data  = imem[imem_addr[9:2]];
   assign dmem_rdata = dmem[dmem_req.addr[9:2]];

   always @(posedge clk) begin
      if (rst_n && dmem_req.we) begin
         dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
         store_log.push_back(dmem_req);
      end
   end

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("Errors found");
      $fatal(1, "timeout: tests still running after %0d cycles", cycles);
   end

   // background data, different for every byte address
   function automatic word_t fill_word(int idx);
      word_t addr;
      addr = word_t'(idx) << 2;
      return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0000;
   endfunction

   // taps for x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsr_next(logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic draw_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[14:0], lfsr_state[0]};
      end
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
         $display("Errors found");
         $fatal(1, "word mismatch");
      end
   endtask

   task automatic check_req(input string name, input dmem_req_t exp, input dmem_req_t act);
      if (act !== exp) begin
         $write("CHECK FAILED %s: expected re=%b we=%b addr=%h wdata=%h",
                name, exp.re, exp.we, exp.addr, exp.wdata);
         $display(" actual re=%b we=%b addr=%h wdata=%h",
                  act.re, act.we, act.addr, act.wdata);
         $display("Errors found");
         $fatal(1, "memory request mismatch");
      end
   endtask

   // called at time zero or on a falling edge; returns on a falling edge after 4 reset cycles
   task automatic restart;
      rst_n = 1'b0;
      for (int i = 0; i < 256; i++) begin
         imem[i]      = '0;
         dmem[i]      = fill_word(i);
         model_mem[i] = fill_word(i);
      end
      for (int i = 0; i < 32; i++) begin
         model_regs[i] = 'x;
      end
      model_regs[0] = '0;
      store_log.delete();
      expect_log.delete();
      pc_slot = int'(RESET_PC >> 2);
      skip_n  = 0;
      repeat (4) @(negedge clk);
   endtask

   task automatic run_and_compare(input string name);
      rst_n = 1'b1;
      while (store_log.size() < expect_log.size()) begin
         @(negedge clk);
      end
      foreach (expect_log[k]) begin
         check_req(name, expect_log[k], store_log[k]);
      end
   endtask

   `include "mips_pipe_tests.svh"

   initial begin
      rst_n      = 1'b0;
      lfsr_state = 16'd76;
      reset_values();
      forwarding_chain();
      load_use_stall();
      branch_shadow();
      zero_register();
      mixed_alu();
      $display("No errors");
      $finish;
   end

endmodule

// File: mips_pipe.f
+incdir+tests
hw/mips_pkg.sv
hw/fetch_stage.sv
hw/pipe_ctrl.sv
hw/reg_file.sv
hw/exec_stage.sv
hw/mem_wb_stage.sv
hw/mips_pipe.sv
tests/mips_pipe_tb.sv

// File: Makefile
# Verilator build of the mips_pipe testbench
# the binary exits non-zero when the testbench stops with $fatal

SIM = obj_dir/Vmips_pipe_tb

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): mips_pipe.f hw/*.sv tests/*.sv tests/*.svh
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module mips_pipe_tb -f mips_pipe.f -o Vmips_pipe_tb

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
